//--- logic/cp_pkg.sv
package cp_pkg;

    localparam int phit_size      = 32;  // load word, imm word and rf data
    localparam int num_col        = 4;   // array columns, one config table each
    localparam int ctrl_width     = 24;  // taken from the low bits of its load word
    localparam int dwidth_rf_add  = 6;   // table and rf address
    localparam int num_entries    = 1 << dwidth_rf_add; // depth of every table
    localparam int dwidth_int     = 8;   // one loop iterator
    localparam int dwidth_double  = 64;  // packed itr bus, zeros then i, j, k
    localparam int entry_sz_state = 32;  // one state table entry

    // load words per table entry: state, then ctrl and imm per column
    // also the width of the write strobe vector
    localparam int words_per_entry = 1 + 2 * num_col;
    localparam int slot_width      = $clog2(words_per_entry);

    // state entry layout, msb first: op | target | bound_i | bound_j | bound_k
    localparam int op_lsb      = 30;
    localparam int op_width    = 2;
    localparam int target_lsb  = 24;  // dwidth_rf_add bits wide
    localparam int bound_i_lsb = 16;  // bounds are dwidth_int bits wide
    localparam int bound_j_lsb = 8;
    localparam int bound_k_lsb = 0;

    // state entry opcodes
    typedef enum logic [op_width-1:0] {
        op_exec = 2'd0,  // run the i/j/k nest
        op_jump = 2'd1,  // pointer <= target
        op_halt = 2'd2,  // program finished
        op_nop  = 2'd3   // skip to next entry
    } state_op_e;

endpackage

//--- logic/table_wr_if.sv
interface table_wr_if;

    import cp_pkg::*;

    logic [dwidth_rf_add-1:0]   wr_add;   // entry index, shared by all tables
    logic [words_per_entry-1:0] wr_en;    // one strobe per load slot
    logic [phit_size-1:0]       wr_data;  // current load word

    // bit 0 -> state table
    // bit 2c+1 -> ctrl of column c, bit 2c+2 -> imm of column c

    modport source (
        output wr_add,
        output wr_en,
        output wr_data
    );

    modport sink (
        input wr_add,
        input wr_en,
        input wr_data
    );

endinterface

//--- logic/state_table.sv
module state_table (
    input  logic                              clk,
    table_wr_if.sink                          wr,
    input  logic [cp_pkg::dwidth_rf_add-1:0]  rd_add,   // smart_ptr
    output logic [cp_pkg::entry_sz_state-1:0] rd_data   // valid one cycle after rd_add
);

    import cp_pkg::*;

    logic [entry_sz_state-1:0] mem [num_entries];

    always_ff @(posedge clk) begin
        if (wr.wr_en[0]) begin
            mem[wr.wr_add] <= wr.wr_data; // state word is a full phit
        end
        rd_data <= mem[rd_add];           // registered read
    end

    // a strobe with a bad address would corrupt an unknown entry
    a_wr_add_known : assert property (
        @(posedge clk) wr.wr_en[0] |-> !$isunknown(wr.wr_add)
    ) else $error("state table write with unknown address");

endmodule

//--- logic/config_table.sv
module config_table #(
    parameter int col = 0  // column index, below num_col
) (
    input  logic                             clk,
    table_wr_if.sink                         wr,
    input  logic [cp_pkg::dwidth_rf_add-1:0] rd_add,
    output logic [cp_pkg::ctrl_width-1:0]    rd_data_ctrl,
    output logic [cp_pkg::phit_size-1:0]     rd_data_imm
);

    import cp_pkg::*;

    logic [ctrl_width-1:0] ctrl_mem [num_entries];
    logic [phit_size-1:0]  imm_mem  [num_entries];
    logic                  wr_ctrl;
    logic                  wr_imm;

    // this column's two slots in the strobe vector
    assign wr_ctrl = wr.wr_en[2 * col + 1];
    assign wr_imm  = wr.wr_en[2 * col + 2];

    // control word memory
    always_ff @(posedge clk) begin
        if (wr_ctrl) begin
            ctrl_mem[wr.wr_add] <= wr.wr_data[ctrl_width-1:0]; // upper bits dropped
        end
        rd_data_ctrl <= ctrl_mem[rd_add];
    end

    // immediate word memory
    always_ff @(posedge clk) begin
        if (wr_imm) begin
            imm_mem[wr.wr_add] <= wr.wr_data;
        end
        rd_data_imm <= imm_mem[rd_add];
    end

    // the loader places ctrl and imm in different slots
    a_one_strobe : assert property (
        @(posedge clk) !(wr_ctrl && wr_imm)
    ) else $error("column %0d ctrl and imm strobes high together", col);

endmodule

//--- logic/table_loader.sv
module table_loader (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             start,                  // start_loader
    input  logic [cp_pkg::dwidth_rf_add-1:0] num_entry_config_table, // N
    input  logic [cp_pkg::dwidth_rf_add-1:0] num_entry_inbound,      // M
    input  logic [cp_pkg::phit_size-1:0]     wr_data_in,
    table_wr_if.source                       wr,
    output logic                             wr_en_rf,
    output logic [cp_pkg::dwidth_rf_add-1:0] wr_add_rf,
    output logic                             done                    // one cycle pulse
);

    import cp_pkg::*;

    typedef enum logic [1:0] {
        ld_idle,
        ld_table,    // 9 words per entry into the tables
        ld_inbound   // M words into the rf
    } ld_state_e;

    ld_state_e              state;
    logic [dwidth_rf_add-1:0] n_entry;    // latched N
    logic [dwidth_rf_add-1:0] n_inbound;  // latched M
    logic [dwidth_rf_add-1:0] entry_cnt;
    logic [slot_width-1:0]    slot_cnt;   // 0 to words_per_entry-1
    logic [dwidth_rf_add-1:0] rf_cnt;
    logic                     last_slot;
    logic                     last_entry;
    logic                     last_inbound;

    assign last_slot    = (slot_cnt == slot_width'(words_per_entry - 1));
    assign last_entry   = (entry_cnt == n_entry - 1'b1);
    assign last_inbound = (rf_cnt == n_inbound - 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ld_idle;
            n_entry   <= '0;
            n_inbound <= '0;
            entry_cnt <= '0;
            slot_cnt  <= '0;
            rf_cnt    <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0; // pulse by default
            case (state)
                ld_idle: begin
                    if (start) begin
                        n_entry   <= num_entry_config_table;
                        n_inbound <= num_entry_inbound;
                        entry_cnt <= '0;
                        slot_cnt  <= '0;
                        rf_cnt    <= '0;
                        // empty sections are skipped
                        if (num_entry_config_table != '0) begin
                            state <= ld_table;
                        end else if (num_entry_inbound != '0) begin
                            state <= ld_inbound;
                        end else begin
                            done <= 1'b1;
                        end
                    end
                end
                ld_table: begin
                    if (last_slot) begin
                        slot_cnt  <= '0;
                        entry_cnt <= entry_cnt + 1'b1;
                        if (last_entry) begin
                            if (n_inbound != '0) begin
                                state <= ld_inbound;
                            end else begin
                                state <= ld_idle;
                                done  <= 1'b1;
                            end
                        end
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end
                ld_inbound: begin
                    rf_cnt <= rf_cnt + 1'b1;
                    if (last_inbound) begin
                        state <= ld_idle;
                        done  <= 1'b1;  // one cycle after the last word
                    end
                end
                default: state <= ld_idle;
            endcase
        end
    end

    // load order is state, ctrl col 0..3, imm col 0..3
    // strobe bits interleave per column, ctrl at 2c+1 and imm at 2c+2
    always_comb begin
        wr.wr_en = '0;
        if (state == ld_table) begin
            if (slot_cnt == '0) begin
                wr.wr_en[0] = 1'b1;                                 // state word
            end else if (slot_cnt <= slot_width'(num_col)) begin
                wr.wr_en[2 * (slot_cnt - 1) + 1] = 1'b1;            // ctrl of column slot-1
            end else begin
                wr.wr_en[2 * (slot_cnt - 1 - num_col) + 2] = 1'b1;  // imm of column slot-5
            end
        end
    end

    assign wr.wr_add   = entry_cnt;
    assign wr.wr_data  = wr_data_in;              // word taken in its own cycle
    assign wr_en_rf    = (state == ld_inbound);
    assign wr_add_rf   = rf_cnt;

    a_strobe_onehot : assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(wr.wr_en) && !(wr_en_rf && |wr.wr_en)
    ) else $error("loader strobes not one-hot");

endmodule

//--- logic/loop_sequencer.sv
module loop_sequencer (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              start,           // done_loader
    input  logic [cp_pkg::entry_sz_state-1:0] entry,           // state table read data
    input  logic                              start_stream_in, // low = back-pressure
    output logic [cp_pkg::dwidth_rf_add-1:0]  smart_ptr,
    output logic [cp_pkg::dwidth_int-1:0]     itr_i,           // outer loop
    output logic [cp_pkg::dwidth_int-1:0]     itr_j,
    output logic [cp_pkg::dwidth_int-1:0]     itr_k,           // inner loop, fastest
    output logic                              ready,           // one step this cycle
    output logic                              done
);

    import cp_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,   // table read in flight
        st_decode,  // entry valid
        st_exec,
        st_halted
    } seq_state_e;

    seq_state_e               state;
    state_op_e                op;
    logic [dwidth_rf_add-1:0] target;
    logic [dwidth_int-1:0]    last_i;  // latched at decode
    logic [dwidth_int-1:0]    last_j;
    logic [dwidth_int-1:0]    last_k;
    logic                     wrap_i;
    logic                     wrap_j;
    logic                     wrap_k;

    // bound of 0 runs once like a bound of 1
    function automatic logic [dwidth_int-1:0] last_of(input logic [dwidth_int-1:0] bound);
        return (bound == '0) ? '0 : bound - 1'b1;
    endfunction

    assign op     = state_op_e'(entry[op_lsb +: op_width]);
    assign target = entry[target_lsb +: dwidth_rf_add];

    assign ready  = (state == st_exec) && start_stream_in;
    assign wrap_i = (itr_i == last_i);
    assign wrap_j = (itr_j == last_j);
    assign wrap_k = (itr_k == last_k);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            smart_ptr <= '0;
            itr_i     <= '0;
            itr_j     <= '0;
            itr_k     <= '0;
            last_i    <= '0;
            last_j    <= '0;
            last_k    <= '0;
            done      <= 1'b0;
        end else if (start) begin
            // new program loaded, restart at entry 0
            smart_ptr <= '0;
            state     <= st_fetch;
            done      <= 1'b0;
        end else begin
            case (state)
                st_fetch: state <= st_decode;
                st_decode: begin
                    case (op)
                        op_exec: begin
                            last_i <= last_of(entry[bound_i_lsb +: dwidth_int]);
                            last_j <= last_of(entry[bound_j_lsb +: dwidth_int]);
                            last_k <= last_of(entry[bound_k_lsb +: dwidth_int]);
                            itr_i  <= '0;
                            itr_j  <= '0;
                            itr_k  <= '0;
                            state  <= st_exec;
                        end
                        op_jump: begin
                            smart_ptr <= target;
                            state     <= st_fetch;
                        end
                        op_halt: begin
                            done  <= 1'b1; // held until the next load
                            state <= st_halted;
                        end
                        op_nop: begin
                            smart_ptr <= smart_ptr + 1'b1;
                            state     <= st_fetch;
                        end
                    endcase
                end
                st_exec: begin
                    if (ready) begin
                        // k carries into j, j carries into i
                        if (!wrap_k) begin
                            itr_k <= itr_k + 1'b1;
                        end else begin
                            itr_k <= '0;
                            if (!wrap_j) begin
                                itr_j <= itr_j + 1'b1;
                            end else begin
                                itr_j <= '0;
                                if (!wrap_i) begin
                                    itr_i <= itr_i + 1'b1;
                                end else begin
                                    // last step of the nest
                                    itr_i     <= '0;
                                    smart_ptr <= smart_ptr + 1'b1;
                                    state     <= st_fetch;
                                end
                            end
                        end
                    end
                end
                default: ; // idle and halted wait for start
            endcase
        end
    end

    // a step only ever shows iterators inside the bounds latched at decode
    a_step_in_bounds : assert property (
        @(posedge clk) disable iff (!arst_n)
        ready |-> (itr_i <= last_i) && (itr_j <= last_j) && (itr_k <= last_k)
    ) else $error("iterator past its bound");

    // iterators advance only on a step, never in fetch, decode, idle or halted
    a_no_step_outside_exec : assert property (
        @(posedge clk) disable iff (!arst_n)
        !ready |=> $stable({itr_i, itr_j, itr_k})
    ) else $error("iterators moved without a step in exec");

endmodule

//--- logic/control_plane.sv
module control_plane (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic [cp_pkg::phit_size-1:0]                 wr_data,
    output logic [cp_pkg::ctrl_width*cp_pkg::num_col-1:0] rd_data_ctrl,
    output logic [cp_pkg::phit_size*cp_pkg::num_col-1:0]  rd_data_imm,
    output logic [cp_pkg::entry_sz_state-1:0]            rd_data_state,
    output logic [cp_pkg::dwidth_double-1:0]             itr,
    input  logic                                         start_loader,
    input  logic                                         start_stream_in,
    input  logic [cp_pkg::dwidth_rf_add-1:0]             num_entry_config_table,
    input  logic [cp_pkg::dwidth_rf_add-1:0]             num_entry_inbound,
    output logic                                         ready,
    output logic                                         done,
    output logic                                         wr_en_rf,
    output logic [cp_pkg::dwidth_rf_add-1:0]             wr_add_rf
);

    import cp_pkg::*;

    logic [dwidth_rf_add-1:0] smart_ptr;   // read address of every table
    logic [dwidth_int-1:0]    itr_i;
    logic [dwidth_int-1:0]    itr_j;
    logic [dwidth_int-1:0]    itr_k;
    logic                     done_loader;

    table_wr_if wr_bus ();  // loader -> all tables

    table_loader u_loader (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .start                  (start_loader),
        .num_entry_config_table (num_entry_config_table),
        .num_entry_inbound      (num_entry_inbound),
        .wr_data_in             (wr_data),
        .wr                     (wr_bus),
        .wr_en_rf               (wr_en_rf),
        .wr_add_rf              (wr_add_rf),
        .done                   (done_loader)
    );

    state_table u_state (
        .clk     (clk),
        .wr      (wr_bus),
        .rd_add  (smart_ptr),
        .rd_data (rd_data_state)  // also feeds the sequencer
    );

    // one config table per column, same address and data, own strobes
    for (genvar c = 0; c < num_col; c++) begin : g_col
        config_table #(
            .col (c)
        ) u_cfg (
            .clk          (clk),
            .wr           (wr_bus),
            .rd_add       (smart_ptr),
            .rd_data_ctrl (rd_data_ctrl[c*ctrl_width +: ctrl_width]),
            .rd_data_imm  (rd_data_imm[c*phit_size +: phit_size])
        );
    end

    loop_sequencer u_seq (
        .clk             (clk),
        .arst_n          (arst_n),
        .start           (done_loader),
        .entry           (rd_data_state),
        .start_stream_in (start_stream_in),
        .smart_ptr       (smart_ptr),
        .itr_i           (itr_i),
        .itr_j           (itr_j),
        .itr_k           (itr_k),
        .ready           (ready),
        .done            (done)
    );

    // zeros, then i, j, k with k in the low byte
    assign itr = {{(dwidth_double - 3 * dwidth_int){1'b0}}, itr_i, itr_j, itr_k};

endmodule

//--- dv/cp_checker.sv
module cp_checker (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          start_loader,
    input  logic [cp_pkg::dwidth_rf_add-1:0]              num_entry_config_table,
    input  logic [cp_pkg::dwidth_rf_add-1:0]              num_entry_inbound,
    input  logic [cp_pkg::phit_size-1:0]                  wr_data,
    input  logic                                          wr_en_rf,
    input  logic [cp_pkg::dwidth_rf_add-1:0]              wr_add_rf,
    input  logic                                          ready,
    input  logic                                          done,
    input  logic [cp_pkg::dwidth_double-1:0]              itr,
    input  logic [cp_pkg::ctrl_width*cp_pkg::num_col-1:0] rd_data_ctrl,
    input  logic [cp_pkg::phit_size*cp_pkg::num_col-1:0]  rd_data_imm,
    input  logic [cp_pkg::entry_sz_state-1:0]             rd_data_state,
    output int                                            err_cnt,
    output int                                            chk_cnt,
    output int                                            prog_cnt,
    output int                                            step_cnt  // steps of latest program
);

    import cp_pkg::*;

    logic [entry_sz_state-1:0] state_m [num_entries];  // model copy of the tables
    logic [ctrl_width-1:0]     ctrl_m  [num_col][num_entries];
    logic [phit_size-1:0]      imm_m   [num_col][num_entries];
    logic [31:0]               exp_q   [$];            // {2'b0, ptr, i, j, k} per step
    logic                      loading;
    logic                      done_q;
    int                        word_idx;
    int                        n_tab;
    int                        n_words;                // 9N + M
    int                        err_base;               // error count when the program began

    initial begin
        err_cnt  = 0;
        chk_cnt  = 0;
        prog_cnt = 0;
        step_cnt = 0;
        err_base = 0;
        loading  = 1'b0;
        done_q   = 1'b0;
    end

    task automatic compare_field(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // a bound of 0 still runs one pass
    function automatic int trip_count(input logic [dwidth_int-1:0] bound);
        return (bound == '0) ? 1 : int'(bound);
    endfunction

    // walk the state entries from 0 and queue every step in issue order
    task automatic build_expected();
        logic [dwidth_rf_add-1:0]  ptr;
        logic [entry_sz_state-1:0] e;
        logic                      halted;
        int                        visits;
        int                        ti;
        int                        tj;
        int                        tk;
        ptr      = '0;
        halted   = 1'b0;
        visits   = 0;
        step_cnt = 0;
        err_base = err_cnt;
        exp_q.delete();
        while (!halted && visits < 256) begin  // guards a jump loop in the model
            e = state_m[ptr];
            visits++;
            case (state_op_e'(e[op_lsb +: op_width]))
                op_exec: begin
                    ti = trip_count(e[bound_i_lsb +: dwidth_int]);
                    tj = trip_count(e[bound_j_lsb +: dwidth_int]);
                    tk = trip_count(e[bound_k_lsb +: dwidth_int]);
                    for (int i = 0; i < ti; i++) begin
                        for (int j = 0; j < tj; j++) begin
                            for (int k = 0; k < tk; k++) begin  // k fastest
                                exp_q.push_back({2'b00, ptr, dwidth_int'(i), dwidth_int'(j),
                                                 dwidth_int'(k)});
                            end
                        end
                    end
                    ptr = ptr + 1'b1;
                end
                op_jump: ptr = e[target_lsb +: dwidth_rf_add];
                op_nop:  ptr = ptr + 1'b1;
                default: halted = 1'b1;  // op_halt
            endcase
        end
    endtask

    // slot order per entry is state, ctrl col 0..3, imm col 0..3, then inbound words
    task automatic take_word();
        int e;
        int s;
        e = word_idx / words_per_entry;
        s = word_idx % words_per_entry;
        if (word_idx < words_per_entry * n_tab) begin
            if (s == 0) begin
                state_m[e] = wr_data;
            end else if (s <= num_col) begin
                ctrl_m[s-1][e] = wr_data[ctrl_width-1:0];
            end else begin
                imm_m[s-1-num_col][e] = wr_data;
            end
            compare_field("wr_en_rf", wr_en_rf, 1'b0);
        end else begin
            compare_field("wr_en_rf", wr_en_rf, 1'b1);
            compare_field("wr_add_rf", wr_add_rf, word_idx - words_per_entry * n_tab);
        end
        word_idx++;
        if (word_idx == n_words) begin
            loading = 1'b0;
            build_expected();
        end
    endtask

    task automatic check_step();
        logic [31:0]                   s;
        logic [dwidth_rf_add-1:0]      ptr;
        logic [ctrl_width*num_col-1:0] exp_ctrl;
        logic [phit_size*num_col-1:0]  exp_imm;
        compare_field("done", done, 1'b0);
        step_cnt++;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("[ERROR] %0t ready high although the model expects no more steps", $time);
        end else begin
            s   = exp_q.pop_front();
            ptr = s[29:24];
            for (int c = 0; c < num_col; c++) begin
                exp_ctrl[c*ctrl_width +: ctrl_width] = ctrl_m[c][ptr];
                exp_imm[c*phit_size +: phit_size]    = imm_m[c][ptr];
            end
            compare_field("itr", itr, s[23:0]);  // upper 40 bits must be zero
            compare_field("rd_data_ctrl", rd_data_ctrl, exp_ctrl);
            compare_field("rd_data_imm", rd_data_imm, exp_imm);
            compare_field("rd_data_state", rd_data_state, state_m[ptr]);  // the exec entry
        end
    endtask

    // sample mid cycle away from the driving edge
    always @(negedge clk) begin
        if (!arst_n) begin
            compare_field("ready", ready, 1'b0);
            compare_field("done", done, 1'b0);
            compare_field("wr_en_rf", wr_en_rf, 1'b0);
            loading = 1'b0;
            done_q  = 1'b0;
        end else begin
            if (loading) begin
                take_word();
            end else begin
                compare_field("wr_en_rf", wr_en_rf, 1'b0);
            end
            if (start_loader) begin
                n_tab    = int'(num_entry_config_table);
                n_words  = words_per_entry * n_tab + int'(num_entry_inbound);
                word_idx = 0;
                loading  = (n_words != 0);
            end
            if (ready) begin
                check_step();
            end
            if (done && !done_q) begin  // program just halted
                if (exp_q.size() != 0) begin
                    err_cnt++;
                    $display("[ERROR] %0t done rose with %0d steps never issued", $time,
                             exp_q.size());
                end
                $display("program %0d: %0d steps, %0d errors", prog_cnt, step_cnt,
                         err_cnt - err_base);
                prog_cnt++;
            end
            done_q = done;
        end
    end

endmodule

//--- dv/tb_control_plane.sv
module tb_control_plane;

    import cp_pkg::*;

    localparam int num_prog  = 5;
    localparam int max_entry = 5;

    logic                          clk;
    logic                          arst_n;
    logic [phit_size-1:0]          wr_data;
    logic [ctrl_width*num_col-1:0] rd_data_ctrl;
    logic [phit_size*num_col-1:0]  rd_data_imm;
    logic [entry_sz_state-1:0]     rd_data_state;
    logic [dwidth_double-1:0]      itr;
    logic                          start_loader;
    logic                          start_stream_in;
    logic [dwidth_rf_add-1:0]      num_entry_config_table;
    logic [dwidth_rf_add-1:0]      num_entry_inbound;
    logic                          ready;
    logic                          done;
    logic                          wr_en_rf;
    logic [dwidth_rf_add-1:0]      wr_add_rf;
    int                            err_cnt;
    int                            chk_cnt;
    int                            prog_cnt;
    int                            step_cnt;
    int                            tb_err = 0;
    int                            seed   = 32'hd81e_0ed5;  // ctrl, imm, inbound, stall
    int                            limit;

    // per program: N, M, stall mode, expected steps, state words
    // stall mode 0 streams every cycle, 1 random 3 of 4, 2 fixed mask
    int prog_n     [num_prog] = '{2, 5, 3, 0, 4};
    int prog_m     [num_prog] = '{3, 0, 5, 4, 2};
    int prog_bp    [num_prog] = '{0, 1, 2, 1, 1};
    int prog_steps [num_prog] = '{24, 6, 10, 10, 8};
    // p1 nop, jump 3 over an exec, bound i of 0; p2 bound k of 0
    // p3 loads no entries and reruns p2; p4 jumps forward and back to a halt
    logic [entry_sz_state-1:0] prog_state [num_prog][max_entry] = '{
        '{32'h0002_0304, 32'h8000_0000, 32'h0, 32'h0, 32'h0},
        '{32'hc000_0000, 32'h4300_0000, 32'h0009_0909, 32'h0000_0203, 32'h8000_0000},
        '{32'h0003_0102, 32'h0001_0400, 32'h8000_0000, 32'h0, 32'h0},
        '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h4200_0000, 32'h8000_0000, 32'h0002_0202, 32'h4100_0000, 32'h0}
    };

    control_plane dut (.*);

    cp_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic drive_word(input logic [phit_size-1:0] w);
        @(posedge clk);
        start_loader <= 1'b0;
        wr_data      <= w;
    endtask

    task automatic load_program(input int p);
        @(posedge clk);
        start_loader           <= 1'b1;
        num_entry_config_table <= dwidth_rf_add'(prog_n[p]);
        num_entry_inbound      <= dwidth_rf_add'(prog_m[p]);
        for (int e = 0; e < prog_n[p]; e++) begin
            drive_word(prog_state[p][e]);
            for (int c = 0; c < 2 * num_col; c++) begin
                drive_word($random(seed));  // ctrl words, then imm words
            end
        end
        for (int r = 0; r < prog_m[p]; r++) begin
            drive_word($random(seed));
        end
    endtask

    // stream until done falls for the new load and rises again at the halt
    task automatic stream_program(input int p);
        logic       seen_low;
        logic       finished;
        logic [7:0] mask;
        int         cyc;
        seen_low = (done == 1'b0);
        finished = 1'b0;
        mask     = 8'b1101_1011;
        cyc      = 0;
        while (!finished) begin
            @(posedge clk);
            if (done && seen_low) begin
                finished = 1'b1;
            end else begin
                seen_low = seen_low || !done;
                case (prog_bp[p])
                    0:       start_stream_in <= 1'b1;
                    1:       start_stream_in <= (($random(seed) & 3) != 0);
                    default: start_stream_in <= mask[cyc[2:0]];
                endcase
                cyc++;
            end
        end
        start_stream_in <= 1'b0;
    endtask

    initial begin
        arst_n                 = 1'b0;
        start_loader           = 1'b0;
        start_stream_in        = 1'b0;
        wr_data                = '0;
        num_entry_config_table = '0;
        num_entry_inbound      = '0;
        limit = 1000;
        for (int p = 0; p < num_prog; p++) begin
            limit += 20 * (1 + words_per_entry * prog_n[p] + prog_m[p] + prog_steps[p]);
        end
        fork
            begin
                #(limit);
                $display("[ERROR] %0t watchdog expired, a program never reached done", $time);
                $display("*** TEST FAILED ***");
                $finish;
            end
        join_none
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        for (int p = 0; p < num_prog; p++) begin
            load_program(p);
            stream_program(p);
            if (step_cnt != prog_steps[p]) begin
                tb_err++;
                $display("[ERROR] %0t step_cnt: got %0d, expected %0d", $time, step_cnt,
                         prog_steps[p]);
            end
        end
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d, programs %0d of %0d", chk_cnt, err_cnt + tb_err,
                 prog_cnt, num_prog);
        if (err_cnt == 0 && tb_err == 0 && prog_cnt == num_prog && chk_cnt > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/cp_pkg.sv
logic/table_wr_if.sv
logic/state_table.sv
logic/config_table.sv
logic/table_loader.sv
logic/loop_sequencer.sv
logic/control_plane.sv
dv/cp_checker.sv
dv/tb_control_plane.sv

//--- run_sim.sh
#!/bin/sh
# build and run the control plane testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_control_plane \
    -f sim.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_control_plane > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
